// File: Bender.yml
package:
  name: peripheral_subsystem

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/periph_pkg.sv
      - common/reg_bus_if.sv
      - plic/plic_target.sv
      - plic/rv_plic.sv
      - gpio/gpio.sv
      - design/periph_xbar.sv
      - design/peripheral_subsystem.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/tb_peripheral_subsystem.sv

// File: common/periph_pkg.sv
// Peripheral select encoding
// Register offset, source ID and priority types

`default_nettype none

`include "periph_settings.svh"

package periph_pkg;

  // Select field of the address, other values are unmapped
  typedef enum logic [`SEL_W-1:0] {
    PERIPH_GPIO = 4'd0,
    PERIPH_PLIC = 4'd1
  } periph_sel_e;

  typedef logic [`OFFSET_W-1:0] reg_offset_t;

  typedef logic [`SRC_ID_W-1:0] src_id_t;

  typedef logic [`PRIO_W-1:0] prio_t;

endpackage : periph_pkg

`default_nettype wire

// File: common/periph_settings.svh
// Bus widths, pin and interrupt counts
// Peripheral base address and register offsets

`ifndef PERIPH_SETTINGS_SVH
`define PERIPH_SETTINGS_SVH

`define ADDR_W      32
`define DATA_W      32
`define BE_W        4
`define GPIO_W      8
`define N_EXT_INTR  2
`define N_SRC       16
`define SRC_ID_W    4
`define PRIO_W      2
`define OFFSET_W    8

// Select field sits right above the window offset
`define SEL_LSB     8
`define SEL_W       4
`define PERIPH_BASE 20'h2_0000

`define GPIO_IN_OFS      8'h00
`define GPIO_OUT_OFS     8'h04
`define GPIO_OE_OFS      8'h08
`define GPIO_RISE_EN_OFS 8'h0C
`define GPIO_FALL_EN_OFS 8'h10
`define GPIO_STATUS_OFS  8'h14

// One priority word per source starting here
`define PLIC_PRIO_OFS      8'h00
`define PLIC_PENDING_OFS   8'h40
`define PLIC_ENABLE_OFS    8'h44
`define PLIC_THRESHOLD_OFS 8'h48
`define PLIC_CLAIM_OFS     8'h4C

`endif

// File: common/reg_bus_if.sv
// Register bus between the crossbar and one peripheral
// Host and device modports

`timescale 1ns/1ps
`default_nettype none

`include "periph_settings.svh"

interface reg_bus_if;

  // Single-cycle strobe, no back-pressure
  logic                    valid;
  logic                    write;
  periph_pkg::reg_offset_t offset;
  logic [`DATA_W-1:0]      wdata;
  logic [`BE_W-1:0]        be;

  // Combinational read data from the device
  logic [`DATA_W-1:0]      rdata;

  modport host (
    output valid,
    output write,
    output offset,
    output wdata,
    output be,
    input  rdata
  );

  modport device (
    input  valid,
    input  write,
    input  offset,
    input  wdata,
    input  be,
    output rdata
  );

endinterface : reg_bus_if

`default_nettype wire

// File: design/periph_xbar.sv
// Bus handshake and address decode
// Strobe demux to the peripherals and registered read response

`timescale 1ns/1ps
`default_nettype none

`include "periph_settings.svh"

module periph_xbar (
  input  wire                clk_i,
  input  wire                arst_n_i,

  input  wire                req_i,
  input  wire  [`ADDR_W-1:0] addr_i,
  input  wire                we_i,
  input  wire  [`BE_W-1:0]   be_i,
  input  wire  [`DATA_W-1:0] wdata_i,
  output logic               gnt_o,
  output logic               rvalid_o,
  output logic [`DATA_W-1:0] rdata_o,

  reg_bus_if.host            gpio_bus,
  reg_bus_if.host            plic_bus
);

  logic                    base_hit;
  periph_pkg::periph_sel_e sel;
  logic [`DATA_W-1:0]      rdata_d;

  // Requests are always accepted in the same cycle
  assign gnt_o = req_i;

  assign base_hit = (addr_i[`ADDR_W-1:`SEL_LSB+`SEL_W] == `PERIPH_BASE);
  assign sel      = periph_pkg::periph_sel_e'(addr_i[`SEL_LSB +: `SEL_W]);

  // Command fields go to both windows and only the strobe is decoded
  assign gpio_bus.write  = we_i;
  assign gpio_bus.offset = addr_i[`OFFSET_W-1:0];
  assign gpio_bus.wdata  = wdata_i;
  assign gpio_bus.be     = be_i;

  assign plic_bus.write  = we_i;
  assign plic_bus.offset = addr_i[`OFFSET_W-1:0];
  assign plic_bus.wdata  = wdata_i;
  assign plic_bus.be     = be_i;

  always_comb begin
    gpio_bus.valid = 1'b0;
    plic_bus.valid = 1'b0;
    rdata_d        = '0;
    if (req_i && base_hit) begin
      case (sel)
        periph_pkg::PERIPH_GPIO: begin
          gpio_bus.valid = 1'b1;
          rdata_d        = gpio_bus.rdata;
        end
        periph_pkg::PERIPH_PLIC: begin
          plic_bus.valid = 1'b1;
          rdata_d        = plic_bus.rdata;
        end
        // Unmapped windows read zero and drop writes
        default: begin
          rdata_d = '0;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= rdata_d;
    end
  end

  // A granted request that strobed no peripheral answers with zero
  a_unmapped_reads_zero: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    $past(gnt_o && !gpio_bus.valid && !plic_bus.valid) |-> (rdata_o == '0)
  );

endmodule : periph_xbar

`default_nettype wire

// File: design/peripheral_subsystem.sv
// Peripheral subsystem top level
// Crossbar, GPIO and interrupt controller with the interrupt source vector

`timescale 1ns/1ps
`default_nettype none

`include "periph_settings.svh"

module peripheral_subsystem (
  input  wire                    clk_i,
  input  wire                    arst_n_i,

  input  wire                    req_i,
  input  wire  [`ADDR_W-1:0]     addr_i,
  input  wire                    we_i,
  input  wire  [`BE_W-1:0]       be_i,
  input  wire  [`DATA_W-1:0]     wdata_i,
  output logic                   gnt_o,
  output logic                   rvalid_o,
  output logic [`DATA_W-1:0]     rdata_o,

  input  wire  [`GPIO_W-1:0]     gpio_i,
  output logic [`GPIO_W-1:0]     gpio_o,
  output logic [`GPIO_W-1:0]     gpio_oe_o,

  input  wire  [`N_EXT_INTR-1:0] ext_intr_i,
  output logic                   irq_o
);

  reg_bus_if gpio_bus ();
  reg_bus_if plic_bus ();

  logic [`GPIO_W-1:0] pin_intr;
  logic [`N_SRC-1:0]  intr_src;

  periph_xbar periph_xbar_i (
    .clk_i,
    .arst_n_i,
    .req_i,
    .addr_i,
    .we_i,
    .be_i,
    .wdata_i,
    .gnt_o,
    .rvalid_o,
    .rdata_o,
    .gpio_bus (gpio_bus),
    .plic_bus (plic_bus)
  );

  gpio gpio_0_i (
    .clk_i,
    .arst_n_i,
    .bus        (gpio_bus),
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .pin_intr_o (pin_intr)
  );

  // Source 0 is reserved by the PLIC and stays low
  assign intr_src[0]                                = 1'b0;
  assign intr_src[`GPIO_W:1]                        = pin_intr;
  assign intr_src[`GPIO_W+`N_EXT_INTR:`GPIO_W+1]    = ext_intr_i;
  assign intr_src[`N_SRC-1:`GPIO_W+`N_EXT_INTR+1]   = '0;

  rv_plic rv_plic_0_i (
    .clk_i,
    .arst_n_i,
    .bus        (plic_bus),
    .intr_src_i (intr_src),
    .irq_o
  );

endmodule : peripheral_subsystem

`default_nettype wire

// File: gpio/gpio.sv
// GPIO output, output enable and edge interrupt registers
// Pad input synchronizer and edge detection

`timescale 1ns/1ps
`default_nettype none

`include "periph_settings.svh"

module gpio (
  input  wire                clk_i,
  input  wire                arst_n_i,
  reg_bus_if.device          bus,
  input  wire  [`GPIO_W-1:0] gpio_i,
  output logic [`GPIO_W-1:0] gpio_o,
  output logic [`GPIO_W-1:0] gpio_oe_o,
  output logic [`GPIO_W-1:0] pin_intr_o
);

  logic [`GPIO_W-1:0] out_q;
  logic [`GPIO_W-1:0] oe_q;
  logic [`GPIO_W-1:0] rise_en_q;
  logic [`GPIO_W-1:0] fall_en_q;
  logic [`GPIO_W-1:0] status_q;
  logic [`GPIO_W-1:0] sync1_q;
  logic [`GPIO_W-1:0] sync2_q;
  logic [`GPIO_W-1:0] prev_q;
  logic [`GPIO_W-1:0] wmask;
  logic [`GPIO_W-1:0] wdata;
  logic [`GPIO_W-1:0] edge_set;
  logic [`GPIO_W-1:0] status_clr;
  logic               wr_en;

  assign wr_en = bus.valid && bus.write;
  assign wdata = bus.wdata[`GPIO_W-1:0];

  always_comb begin
    for (int i = 0; i < `GPIO_W; i++) begin
      wmask[i] = bus.be[i/8];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_q     <= '0;
      oe_q      <= '0;
      rise_en_q <= '0;
      fall_en_q <= '0;
    end else if (wr_en) begin
      case (bus.offset)
        `GPIO_OUT_OFS:     out_q     <= (out_q & ~wmask) | (wdata & wmask);
        `GPIO_OE_OFS:      oe_q      <= (oe_q & ~wmask) | (wdata & wmask);
        `GPIO_RISE_EN_OFS: rise_en_q <= (rise_en_q & ~wmask) | (wdata & wmask);
        `GPIO_FALL_EN_OFS: fall_en_q <= (fall_en_q & ~wmask) | (wdata & wmask);
        default: ;
      endcase
    end
  end

  // Two-stage synchronizer whose second stage is the IN register
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
    end
  end

  assign edge_set   = (sync2_q & ~prev_q & rise_en_q) | (~sync2_q & prev_q & fall_en_q);
  assign status_clr = (wr_en && bus.offset == `GPIO_STATUS_OFS) ? (wdata & wmask) : '0;

  // A new edge wins over a clear in the same cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      status_q <= '0;
    end else begin
      status_q <= (status_q & ~status_clr) | edge_set;
    end
  end

  always_comb begin
    bus.rdata = '0;
    case (bus.offset)
      `GPIO_IN_OFS:      bus.rdata[`GPIO_W-1:0] = sync2_q;
      `GPIO_OUT_OFS:     bus.rdata[`GPIO_W-1:0] = out_q;
      `GPIO_OE_OFS:      bus.rdata[`GPIO_W-1:0] = oe_q;
      `GPIO_RISE_EN_OFS: bus.rdata[`GPIO_W-1:0] = rise_en_q;
      `GPIO_FALL_EN_OFS: bus.rdata[`GPIO_W-1:0] = fall_en_q;
      `GPIO_STATUS_OFS:  bus.rdata[`GPIO_W-1:0] = status_q;
      default: ;
    endcase
  end

  assign gpio_o     = out_q;
  assign gpio_oe_o  = oe_q;
  assign pin_intr_o = status_q;

  // A status bit only rises after the IN value changed on an enabled pin
  a_status_needs_edge: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (status_q & ~$past(status_q) & ~$past((sync2_q ^ prev_q) & (rise_en_q | fall_en_q))) == '0
  );

endmodule : gpio

`default_nettype wire

// File: plic/plic_target.sv
// Highest-priority selection for the single interrupt target

`timescale 1ns/1ps
`default_nettype none

`include "periph_settings.svh"

module plic_target (
  input  wire [`N_SRC-1:0]                    pending_i,
  input  wire [`N_SRC-1:0]                    enable_i,
  input  wire periph_pkg::prio_t [`N_SRC-1:0] prio_i,
  input  wire periph_pkg::prio_t              threshold_i,
  output periph_pkg::src_id_t                 claim_id_o
);

  periph_pkg::prio_t   best_prio;
  periph_pkg::src_id_t best_id;

  // Strict compare keeps the lower ID on a tie
  always_comb begin
    best_prio = threshold_i;
    best_id   = '0;
    for (int i = 1; i < `N_SRC; i++) begin
      if (pending_i[i] && enable_i[i] && (prio_i[i] > best_prio)) begin
        best_prio = prio_i[i];
        best_id   = periph_pkg::src_id_t'(i);
      end
    end
  end

  // Zero means nothing above threshold
  assign claim_id_o = best_id;

endmodule : plic_target

`default_nettype wire

// File: plic/rv_plic.sv
// Interrupt controller with level gateways
// Priority, enable and threshold registers, claim and complete

`timescale 1ns/1ps
`default_nettype none

`include "periph_settings.svh"

module rv_plic (
  input  wire               clk_i,
  input  wire               arst_n_i,
  reg_bus_if.device         bus,
  input  wire  [`N_SRC-1:0] intr_src_i,
  output logic              irq_o
);

  periph_pkg::prio_t [`N_SRC-1:0] prio_q;
  periph_pkg::prio_t              threshold_q;
  logic [`N_SRC-1:0]              enable_q;
  logic [`N_SRC-1:0]              pending_q;
  logic [`N_SRC-1:0]              pending_d;
  logic [`N_SRC-1:0]              in_service_q;
  logic [`N_SRC-1:0]              in_service_d;
  logic [`N_SRC-1:0]              en_mask;
  periph_pkg::reg_offset_t        prio_rel;
  logic                           prio_hit;
  periph_pkg::src_id_t            prio_idx;
  periph_pkg::src_id_t            claim_id;
  periph_pkg::src_id_t            complete_id;
  logic                           wr_en;
  logic                           claim_rd;
  logic                           claim_wr;

  assign wr_en    = bus.valid && bus.write;
  assign claim_rd = bus.valid && !bus.write && (bus.offset == `PLIC_CLAIM_OFS);
  assign claim_wr = wr_en && bus.be[0] && (bus.offset == `PLIC_CLAIM_OFS);

  assign complete_id = bus.wdata[`SRC_ID_W-1:0];

  // Priority words, one per source
  assign prio_rel = bus.offset - `PLIC_PRIO_OFS;
  assign prio_hit = (prio_rel < 4 * `N_SRC);
  assign prio_idx = prio_rel[2 +: `SRC_ID_W];

  always_comb begin
    for (int i = 0; i < `N_SRC; i++) begin
      en_mask[i] = bus.be[i/8];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      prio_q      <= '0;
      enable_q    <= '0;
      threshold_q <= '0;
    end else if (wr_en) begin
      // Source 0 keeps priority zero
      if (prio_hit && prio_idx != '0 && bus.be[0]) begin
        prio_q[prio_idx] <= bus.wdata[`PRIO_W-1:0];
      end
      if (bus.offset == `PLIC_ENABLE_OFS) begin
        enable_q <= (enable_q & ~en_mask) | (bus.wdata[`N_SRC-1:0] & en_mask);
      end
      if (bus.offset == `PLIC_THRESHOLD_OFS && bus.be[0]) begin
        threshold_q <= bus.wdata[`PRIO_W-1:0];
      end
    end
  end

  // Level gateways, a source in service cannot pend again
  always_comb begin
    pending_d    = pending_q | (intr_src_i & ~in_service_q);
    in_service_d = in_service_q;
    pending_d[0] = 1'b0;
    if (claim_rd && claim_id != '0) begin
      pending_d[claim_id]    = 1'b0;
      in_service_d[claim_id] = 1'b1;
    end
    if (claim_wr) begin
      in_service_d[complete_id] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q    <= '0;
      in_service_q <= '0;
    end else begin
      pending_q    <= pending_d;
      in_service_q <= in_service_d;
    end
  end

  plic_target plic_target_i (
    .pending_i   (pending_q),
    .enable_i    (enable_q),
    .prio_i      (prio_q),
    .threshold_i (threshold_q),
    .claim_id_o  (claim_id)
  );

  assign irq_o = (claim_id != '0);

  always_comb begin
    bus.rdata = '0;
    if (prio_hit) begin
      bus.rdata[`PRIO_W-1:0] = prio_q[prio_idx];
    end else begin
      case (bus.offset)
        `PLIC_PENDING_OFS:   bus.rdata[`N_SRC-1:0]    = pending_q;
        `PLIC_ENABLE_OFS:    bus.rdata[`N_SRC-1:0]    = enable_q;
        `PLIC_THRESHOLD_OFS: bus.rdata[`PRIO_W-1:0]   = threshold_q;
        `PLIC_CLAIM_OFS:     bus.rdata[`SRC_ID_W-1:0] = claim_id;
        default: ;
      endcase
    end
  end

  // The winner from the target really is an eligible source
  a_irq_has_candidate: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    irq_o |-> (pending_q[claim_id] && enable_q[claim_id] && prio_q[claim_id] > threshold_q)
  );

endmodule : rv_plic

`default_nettype wire

// File: tb.f
+incdir+common
common/periph_pkg.sv
common/reg_bus_if.sv
plic/plic_target.sv
plic/rv_plic.sv
gpio/gpio.sv
design/periph_xbar.sv
design/peripheral_subsystem.sv
verif/tb_peripheral_subsystem.sv

// File: verif/tb_peripheral_subsystem.sv
// Testbench for the peripheral subsystem
// LFSR stimulus, cycle model of GPIO and PLIC, response checks

`timescale 1ns/1ps
`default_nettype none

`include "periph_settings.svh"

module tb_peripheral_subsystem;

  localparam int N_TRANS = 400;
  localparam int TIMEOUT = N_TRANS * 8 + 200;

  logic                   clk;
  logic                   arst_n;
  logic                   req;
  logic [`ADDR_W-1:0]     addr;
  logic                   we;
  logic [`BE_W-1:0]       be;
  logic [`DATA_W-1:0]     wdata;
  logic                   gnt;
  logic                   rvalid;
  logic [`DATA_W-1:0]     rdata;
  logic [`GPIO_W-1:0]     gpio_in;
  logic [`GPIO_W-1:0]     gpio_out;
  logic [`GPIO_W-1:0]     gpio_oe;
  logic [`N_EXT_INTR-1:0] ext_intr;
  logic                   irq;

  // Model state
  logic [`GPIO_W-1:0] m_out, m_oe, m_rise, m_fall, m_status;
  logic [`GPIO_W-1:0] m_sync1, m_sync2, m_prev;
  logic [`PRIO_W-1:0] m_prio [`N_SRC];
  logic [`PRIO_W-1:0] m_thr;
  logic [`N_SRC-1:0]  m_en, m_pend, m_insvc;
  logic               exp_rvalid;
  logic               exp_is_claim;
  logic [`DATA_W-1:0] exp_rdata;
  logic [3:0]         last_claim;

  // Temporaries of the model step
  logic               hit, gpio_acc, plic_acc;
  logic [7:0]         off;
  logic [3:0]         win;
  logic [`DATA_W-1:0] rd;
  logic [`GPIO_W-1:0] edges, clr;
  logic [`N_SRC-1:0]  src;

  logic [31:0] lfsr;
  int          hold_cnt;
  int          n_trans;
  int          n_cycles;
  int          n_checks;
  int          n_mism;
  int          n_other;

  peripheral_subsystem i_dut (
    .clk_i      (clk),
    .arst_n_i   (arst_n),
    .req_i      (req),
    .addr_i     (addr),
    .we_i       (we),
    .be_i       (be),
    .wdata_i    (wdata),
    .gnt_o      (gnt),
    .rvalid_o   (rvalid),
    .rdata_o    (rdata),
    .gpio_i     (gpio_in),
    .gpio_o     (gpio_out),
    .gpio_oe_o  (gpio_oe),
    .ext_intr_i (ext_intr),
    .irq_o      (irq)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // Highest priority strictly above threshold with ties to the lower ID
  function automatic logic [3:0] best_source();
    logic [3:0]         id;
    logic [`PRIO_W-1:0] p;
    id = '0;
    p  = '0;
    for (int i = 1; i < `N_SRC; i++) begin
      if (m_pend[i] && m_en[i] && m_prio[i] > m_thr && (id == 0 || m_prio[i] > p)) begin
        id = 4'(i);
        p  = m_prio[i];
      end
    end
    return id;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    assert (act === exp) else begin
      n_mism++;
      $display("mismatch at %0d ns: %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  // Model step at each clock edge from the inputs driven half a cycle before
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      {m_out, m_oe, m_rise, m_fall, m_status} = '0;
      {m_sync1, m_sync2, m_prev} = '0;
      for (int i = 0; i < `N_SRC; i++) m_prio[i] = '0;
      {m_thr, m_en, m_pend, m_insvc} = '0;
      exp_rvalid   = 1'b0;
      exp_is_claim = 1'b0;
      last_claim   = '0;
    end else begin
      check_val("gnt_o", 32'(req), 32'(gnt));
      hit      = (addr[`ADDR_W-1:12] == `PERIPH_BASE);
      off      = addr[7:0];
      gpio_acc = req && hit && (addr[11:8] == periph_pkg::PERIPH_GPIO);
      plic_acc = req && hit && (addr[11:8] == periph_pkg::PERIPH_PLIC);
      win      = best_source();
      rd       = '0;
      if (gpio_acc) begin
        case (off)
          `GPIO_IN_OFS:      rd = 32'(m_sync2);
          `GPIO_OUT_OFS:     rd = 32'(m_out);
          `GPIO_OE_OFS:      rd = 32'(m_oe);
          `GPIO_RISE_EN_OFS: rd = 32'(m_rise);
          `GPIO_FALL_EN_OFS: rd = 32'(m_fall);
          `GPIO_STATUS_OFS:  rd = 32'(m_status);
          default:           rd = '0;
        endcase
      end else if (plic_acc) begin
        if (off < 8'h40) rd = 32'(m_prio[off[5:2]]);
        else if (off == `PLIC_PENDING_OFS) rd = 32'(m_pend);
        else if (off == `PLIC_ENABLE_OFS) rd = 32'(m_en);
        else if (off == `PLIC_THRESHOLD_OFS) rd = 32'(m_thr);
        else if (off == `PLIC_CLAIM_OFS) rd = 32'(win);
      end
      exp_rvalid   = req;
      exp_is_claim = plic_acc && !we && off == `PLIC_CLAIM_OFS;
      if (req) exp_rdata = rd;

      // Interrupt gateways see the status before this edge
      src    = {5'b0, ext_intr, m_status, 1'b0};
      m_pend = m_pend | (src & ~m_insvc);
      m_pend[0] = 1'b0;
      if (exp_is_claim && win != 0) begin
        m_pend[win]  = 1'b0;
        m_insvc[win] = 1'b1;
        last_claim   = win;
      end
      if (plic_acc && we && be[0]) begin
        if (off == `PLIC_CLAIM_OFS) m_insvc[wdata[3:0]] = 1'b0;
        if (off < 8'h40 && off[5:2] != 0) m_prio[off[5:2]] = wdata[1:0];
        if (off == `PLIC_THRESHOLD_OFS) m_thr = wdata[1:0];
        if (off == `PLIC_ENABLE_OFS) m_en[7:0] = wdata[7:0];
      end
      if (plic_acc && we && be[1] && off == `PLIC_ENABLE_OFS) m_en[15:8] = wdata[15:8];

      edges = (m_sync2 & ~m_prev & m_rise) | (~m_sync2 & m_prev & m_fall);
      clr   = (gpio_acc && we && be[0] && off == `GPIO_STATUS_OFS) ? wdata[7:0] : '0;
      m_status = (m_status & ~clr) | edges;
      m_prev   = m_sync2;
      m_sync2  = m_sync1;
      m_sync1  = gpio_in;
      if (gpio_acc && we && be[0]) begin
        case (off)
          `GPIO_OUT_OFS:     m_out  = wdata[7:0];
          `GPIO_OE_OFS:      m_oe   = wdata[7:0];
          `GPIO_RISE_EN_OFS: m_rise = wdata[7:0];
          `GPIO_FALL_EN_OFS: m_fall = wdata[7:0];
          default: ;
        endcase
      end
    end
  end

  task automatic check_outputs();
    check_val("rvalid_o", 32'(exp_rvalid), 32'(rvalid));
    if (exp_rvalid) begin
      check_val("rdata_o", exp_rdata, rdata);
    end
    if (exp_rvalid && exp_is_claim) begin
      n_checks++;
      assert (rdata < 11) else begin
        n_other++;
        $display("claim returned source %0d, which has no interrupt line", rdata);
      end
    end
    check_val("gpio_o", 32'(m_out), 32'(gpio_out));
    check_val("gpio_oe_o", 32'(m_oe), 32'(gpio_oe));
    check_val("irq_o", 32'(best_source() != 0), 32'(irq));
  endtask

  task automatic drive_next();
    logic [2:0] kind;
    logic [4:0] idx;
    if (hold_cnt == 0) begin
      gpio_in  = next_bits(8);
      hold_cnt = 5 + next_bits(2);
    end else begin
      hold_cnt--;
    end
    if (next_bits(3) == 0) ext_intr = next_bits(2);
    req = (next_bits(2) != 0);
    if (req) begin
      n_trans++;
      kind  = next_bits(3);
      we    = next_bits(1);
      be    = next_bits(4);
      wdata = next_bits(32);
      idx   = next_bits(5);
      case (kind)
        3'd0, 3'd1, 3'd2: begin
          idx[2:0] = (idx[2:0] > 5) ? idx[2:0] - 6 : idx[2:0];
          addr = {`PERIPH_BASE, periph_pkg::PERIPH_GPIO, 3'b0, idx[2:0], 2'b00};
        end
        3'd3, 3'd4, 3'd5: begin
          off = idx[4] ? (idx[3:2] == 2'b11 ? 8'h80 : 8'h40 + 8'(idx[1:0]) * 4) : 8'(idx) * 4;
          addr = {`PERIPH_BASE, periph_pkg::PERIPH_PLIC, off};
        end
        3'd6: begin
          if (next_bits(1)) addr = next_bits(32);
          else addr = {`PERIPH_BASE, 4'd2 + 4'(next_bits(3)), 8'(next_bits(8))};
        end
        default: begin
          addr = {`PERIPH_BASE, periph_pkg::PERIPH_PLIC, `PLIC_CLAIM_OFS};
          be   = be | 4'b0001;
          if (we) wdata = {28'b0, last_claim};
        end
      endcase
    end
  endtask

  always @(posedge clk) begin
    n_cycles++;
    if (n_cycles >= TIMEOUT) begin
      $display("run stopped after %0d cycles without reaching the end of the test", n_cycles);
      $display("Something failed");
      $finish;
    end
  end

  initial begin
    lfsr     = 32'h92e6_7760;
    {req, we, be, addr, wdata} = '0;
    gpio_in  = '0;
    ext_intr = '0;
    arst_n   = 1'b0;
    hold_cnt = 0;
    {n_trans, n_cycles, n_checks, n_mism, n_other} = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    while (n_trans < N_TRANS) begin
      @(negedge clk);
      check_outputs();
      drive_next();
    end
    @(negedge clk);
    check_outputs();
    req = 1'b0;
    repeat (3) begin
      @(negedge clk);
      check_outputs();
    end
    $display("checks %0d, mismatches %0d, other errors %0d", n_checks, n_mism, n_other);
    if (n_mism == 0 && n_other == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule : tb_peripheral_subsystem

`default_nettype wire
